// File: rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int addr_width   = 16;
    localparam int offset_width = 3;
    localparam int set_count    = 8;
    localparam int set_width    = 3;
    localparam int way_count    = 4;
    localparam int way_width    = 2;
    localparam int tag_width    = 10;
    localparam int line_width   = 64;
    localparam int word_width   = 32;
    localparam int dest_width   = 6;
    localparam int plru_width   = 3;

    // APB register offsets
    localparam logic [3:0] reg_ctrl       = 4'h0;
    localparam logic [3:0] reg_hit_count  = 4'h4;
    localparam logic [3:0] reg_miss_count = 4'h8;

    typedef enum logic [1:0] {byte_size, half_size, word_size, line_size} mem_size_e;

    typedef enum logic {bus_load, bus_store} bus_cmd_e;

    typedef enum logic [1:0] {idle, request, wait_fill, fill} miss_state_e;

    typedef struct packed {
        logic                  valid;
        logic [addr_width-1:0] addr;
        mem_size_e             size;
        logic                  is_signed;
        logic [dest_width-1:0] dest;
    } load_req_t;

    typedef struct packed {
        logic                  valid;
        logic [word_width-1:0] value;
        logic [dest_width-1:0] dest;
    } load_resp_t;

    typedef struct packed {
        logic                  valid;
        logic [addr_width-1:0] addr;
        mem_size_e             size;
        logic [word_width-1:0] data;
    } store_req_t;

    // Loads ask for a whole aligned line, stores carry their value in the low word
    typedef struct packed {
        logic                  valid;
        bus_cmd_e              cmd;
        logic [addr_width-1:0] addr;
        mem_size_e             size;
        logic [line_width-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic                  valid;
        logic [line_width-1:0] data;
    } mem_resp_t;

    typedef struct packed {
        logic enable;
        logic invalidate;
    } cache_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/dcache_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_regs (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [3:0]                        paddr,
    input  logic [dcache_pkg::word_width-1:0] pwdata,
    output logic [dcache_pkg::word_width-1:0] prdata,
    output logic                              pready,
    output logic                              pslverr,
    input  logic                              hit_event,
    input  logic                              miss_event,
    output dcache_pkg::cache_ctrl_t           cache_ctrl
);
    import dcache_pkg::*;

    logic [word_width-1:0] hit_count;
    logic [word_width-1:0] miss_count;
    logic                  access;
    logic                  mapped;

    assign access  = psel && penable;
    assign mapped  = paddr inside {reg_ctrl, reg_hit_count, reg_miss_count};
    assign pready  = 1'b1;
    assign pslverr = access && !mapped;

    always_comb begin
        case (paddr)
            reg_ctrl:       prdata = word_width'({cache_ctrl.invalidate, cache_ctrl.enable});
            reg_hit_count:  prdata = hit_count;
            reg_miss_count: prdata = miss_count;
            default:        prdata = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cache_ctrl.enable     <= 1'b1;
            cache_ctrl.invalidate <= 1'b0;
            hit_count             <= '0;
            miss_count            <= '0;
        end else begin
            // Invalidate lives for one cycle only
            cache_ctrl.invalidate <= 1'b0;
            if (access && pwrite && paddr == reg_ctrl) begin
                cache_ctrl.enable     <= pwdata[0];
                cache_ctrl.invalidate <= pwdata[1];
            end
            // Counters stick at all ones
            if (hit_event && hit_count != '1) begin
                hit_count <= hit_count + 1'b1;
            end
            if (miss_event && miss_count != '1) begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset) penable |-> psel)
        else $error("APB penable seen without psel");

endmodule

`default_nettype wire

// File: rtl/tree_plru.sv
`timescale 1ns/1ps
`default_nettype none

module tree_plru (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [dcache_pkg::set_width-1:0] lookup_set,
    input  logic                             update,
    input  logic [dcache_pkg::set_width-1:0] update_set,
    input  logic [dcache_pkg::way_width-1:0] update_way,
    output logic [dcache_pkg::way_width-1:0] lru_way
);
    import dcache_pkg::*;

    // Each set holds root in bit 2, left in bit 1 and right in bit 0
    logic [set_count-1:0][plru_width-1:0] tree_q;
    logic [plru_width-1:0]                cur;

    assign cur     = tree_q[lookup_set];
    assign lru_way = cur[2] ? {1'b1, cur[0]} : {1'b0, cur[1]};

    // Each touched bit is turned away from the accessed way
    always_ff @(posedge clock) begin
        if (reset) begin
            tree_q <= '0;
        end else if (update) begin
            if (update_way[1]) begin
                tree_q[update_set][2] <= 1'b0;
                tree_q[update_set][0] <= ~update_way[0];
            end else begin
                tree_q[update_set][2] <= 1'b1;
                tree_q[update_set][1] <= ~update_way[0];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/dcache_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_array (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [dcache_pkg::addr_width-1:0] lookup_addr,
    input  dcache_pkg::cache_ctrl_t           cache_ctrl,
    input  dcache_pkg::store_req_t            store_req,
    input  logic                              store_accept,
    input  logic                              fill_en,
    input  logic [dcache_pkg::set_width-1:0]  fill_set,
    input  logic [dcache_pkg::tag_width-1:0]  fill_tag,
    input  logic [dcache_pkg::line_width-1:0] fill_data,
    input  logic [dcache_pkg::way_width-1:0]  plru_way,
    output logic                              hit,
    output logic [dcache_pkg::way_width-1:0]  hit_way,
    output logic [dcache_pkg::line_width-1:0] hit_line,
    output logic [dcache_pkg::set_width-1:0]  plru_set,
    output logic                              plru_update,
    output logic [dcache_pkg::way_width-1:0]  plru_update_way
);
    import dcache_pkg::*;

    logic [set_count-1:0][way_count-1:0] valid_q;
    logic [tag_width-1:0]                tag_q [set_count][way_count];
    logic [line_width-1:0]               data_q [set_count][way_count];

    logic [addr_width-1:0]   addr;
    logic [set_width-1:0]    set_idx;
    logic [tag_width-1:0]    tag;
    logic [offset_width-1:0] offset;
    logic [way_count-1:0]    way_hit;
    logic [way_width-1:0]    victim;
    logic [line_width-1:0]   store_line;

    // A pending store owns the lookup port
    assign addr    = store_req.valid ? store_req.addr : lookup_addr;
    assign set_idx = addr[offset_width +: set_width];
    assign tag     = addr[addr_width-1 -: tag_width];
    assign offset  = addr[offset_width-1:0];

    always_comb begin
        hit_way = '0;
        for (int w = way_count - 1; w >= 0; w--) begin
            way_hit[w] = valid_q[set_idx][w] && tag_q[set_idx][w] == tag;
            if (way_hit[w]) begin
                hit_way = way_width'(w);
            end
        end
    end

    assign hit      = |way_hit;
    assign hit_line = data_q[set_idx][hit_way];

    // Lowest invalid way first, PLRU choice once the set is full
    always_comb begin
        victim = plru_way;
        for (int w = way_count - 1; w >= 0; w--) begin
            if (!valid_q[fill_set][w]) begin
                victim = way_width'(w);
            end
        end
    end

    assign plru_set        = fill_en ? fill_set : set_idx;
    assign plru_update     = fill_en;
    assign plru_update_way = victim;

    always_comb begin
        store_line = hit_line;
        case (store_req.size)
            byte_size: store_line[offset*8 +: 8] = store_req.data[7:0];
            half_size: store_line[offset[2:1]*16 +: 16] = store_req.data[15:0];
            default:   store_line[offset[2]*word_width +: word_width] = store_req.data;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            if (cache_ctrl.invalidate) begin
                valid_q <= '0;
            end
            if (fill_en) begin
                valid_q[fill_set][victim] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill_en) begin
            tag_q[fill_set][victim]  <= fill_tag;
            data_q[fill_set][victim] <= fill_data;
        end
        if (store_accept && hit) begin
            data_q[set_idx][hit_way] <= store_line;
        end
    end

    // Fills only follow misses, so a line never lives in two ways
    assert property (@(posedge clock) disable iff (reset) $onehot0(way_hit))
        else $error("tag matched in more than one way");

endmodule

`default_nettype wire

// File: rtl/miss_unit.sv
`timescale 1ns/1ps
`default_nettype none

module miss_unit (
    input  logic                             clock,
    input  logic                             reset,
    input  dcache_pkg::load_req_t            load_req,
    input  dcache_pkg::store_req_t           store_req,
    output logic                             load_ready,
    output logic                             store_ready,
    input  dcache_pkg::cache_ctrl_t          cache_ctrl,
    input  logic                             hit,
    output dcache_pkg::mem_req_t             mem_req,
    input  logic                             mem_ready,
    input  dcache_pkg::mem_resp_t            mem_resp,
    output logic                             fill_en,
    output logic [dcache_pkg::set_width-1:0] fill_set,
    output logic [dcache_pkg::tag_width-1:0] fill_tag,
    output logic                             hit_event,
    output logic                             miss_event,
    output logic                             extract_en,
    output logic                             extract_sel_fill,
    output dcache_pkg::load_req_t            extract_req
);
    import dcache_pkg::*;

    miss_state_e state;
    miss_state_e state_next;
    load_req_t   miss_load;
    logic        alloc;
    logic        free;
    logic        load_accept;
    logic        store_accept;

    // Nothing new while a miss is open or memory has not taken the last request
    assign free         = state == idle && !mem_req.valid;
    assign store_ready  = free;
    assign load_ready   = free && !store_req.valid;
    assign load_accept  = load_req.valid && load_ready;
    assign store_accept = store_req.valid && store_ready;

    assign hit_event  = load_accept && hit && cache_ctrl.enable;
    assign miss_event = load_accept && !(hit && cache_ctrl.enable);

    assign extract_sel_fill = state == wait_fill;
    assign extract_en       = hit_event || (extract_sel_fill && mem_resp.valid);
    assign extract_req      = extract_sel_fill ? miss_load : load_req;
    assign fill_en          = extract_sel_fill && mem_resp.valid && alloc;
    assign fill_set         = miss_load.addr[offset_width +: set_width];
    assign fill_tag         = miss_load.addr[addr_width-1 -: tag_width];

    always_comb begin
        state_next = state;
        case (state)
            idle:      state_next = miss_event ? request : idle;
            request:   state_next = mem_ready ? wait_fill : request;
            wait_fill: state_next = mem_resp.valid ? fill : wait_fill;
            default:   state_next = idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state         <= idle;
            mem_req.valid <= 1'b0;
        end else begin
            state <= state_next;
            if (store_accept || miss_event) begin
                mem_req.valid <= 1'b1;
            end else if (mem_ready) begin
                mem_req.valid <= 1'b0;
            end
        end
        if (store_accept) begin
            mem_req.cmd  <= bus_store;
            mem_req.addr <= store_req.addr;
            mem_req.size <= store_req.size;
            mem_req.data <= line_width'(store_req.data);
        end else if (miss_event) begin
            mem_req.cmd  <= bus_load;
            mem_req.addr <= {load_req.addr[addr_width-1:offset_width], offset_width'(0)};
            mem_req.size <= line_size;
            mem_req.data <= '0;
        end
        // Enable is sampled at the miss so a line is never allocated twice
        if (miss_event) begin
            miss_load <= load_req;
            alloc     <= cache_ctrl.enable;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        mem_req.valid && !mem_ready |=> $stable(mem_req))
        else $error("mem_req changed while stalled");

endmodule

`default_nettype wire

// File: rtl/load_extract.sv
`timescale 1ns/1ps
`default_nettype none

module load_extract (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [dcache_pkg::line_width-1:0]   line,
    input  logic [dcache_pkg::offset_width-1:0] offset,
    input  dcache_pkg::mem_size_e               size,
    input  logic                                is_signed,
    input  logic [dcache_pkg::dest_width-1:0]   dest,
    input  logic                                capture,
    output dcache_pkg::load_resp_t              load_resp
);
    import dcache_pkg::*;

    logic [7:0]            byte_val;
    logic [15:0]           half_val;
    logic [word_width-1:0] word_val;
    logic [word_width-1:0] value;

    assign byte_val = line[offset*8 +: 8];
    assign half_val = line[offset[2:1]*16 +: 16];
    assign word_val = line[offset[2]*word_width +: word_width];

    always_comb begin
        case (size)
            byte_size: value = is_signed ? {{24{byte_val[7]}}, byte_val} : {24'd0, byte_val};
            half_size: value = is_signed ? {{16{half_val[15]}}, half_val} : {16'd0, half_val};
            default:   value = word_val;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            load_resp.valid <= 1'b0;
        end else begin
            load_resp.valid <= capture;
        end
        if (capture) begin
            load_resp.value <= value;
            load_resp.dest  <= dest;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                              clock,
    input  logic                              reset,
    input  dcache_pkg::load_req_t             load_req,
    output logic                              load_ready,
    output dcache_pkg::load_resp_t            load_resp,
    input  dcache_pkg::store_req_t            store_req,
    output logic                              store_ready,
    output dcache_pkg::mem_req_t              mem_req,
    input  logic                              mem_ready,
    input  dcache_pkg::mem_resp_t             mem_resp,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [3:0]                        paddr,
    input  logic [dcache_pkg::word_width-1:0] pwdata,
    output logic [dcache_pkg::word_width-1:0] prdata,
    output logic                              pready,
    output logic                              pslverr
);
    import dcache_pkg::*;

    cache_ctrl_t           cache_ctrl;
    load_req_t             extract_req;
    logic                  hit;
    logic                  hit_event;
    logic                  miss_event;
    logic                  fill_en;
    logic                  extract_en;
    logic                  extract_sel_fill;
    logic                  store_accept;
    logic                  plru_update;
    logic                  plru_touch;
    logic [set_width-1:0]  fill_set;
    logic [set_width-1:0]  plru_set;
    logic [tag_width-1:0]  fill_tag;
    logic [way_width-1:0]  hit_way;
    logic [way_width-1:0]  plru_way;
    logic [way_width-1:0]  plru_update_way;
    logic [way_width-1:0]  plru_touch_way;
    logic [line_width-1:0] hit_line;
    logic [line_width-1:0] extract_line;

    assign store_accept = store_req.valid && store_ready;
    assign extract_line = extract_sel_fill ? mem_resp.data : hit_line;
    // PLRU moves on fills and on accepted load hits only
    assign plru_touch     = plru_update || hit_event;
    assign plru_touch_way = plru_update ? plru_update_way : hit_way;

    dcache_regs u_regs (
        .clock      (clock),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .hit_event  (hit_event),
        .miss_event (miss_event),
        .cache_ctrl (cache_ctrl)
    );

    miss_unit u_miss (
        .clock            (clock),
        .reset            (reset),
        .load_req         (load_req),
        .store_req        (store_req),
        .load_ready       (load_ready),
        .store_ready      (store_ready),
        .cache_ctrl       (cache_ctrl),
        .hit              (hit),
        .mem_req          (mem_req),
        .mem_ready        (mem_ready),
        .mem_resp         (mem_resp),
        .fill_en          (fill_en),
        .fill_set         (fill_set),
        .fill_tag         (fill_tag),
        .hit_event        (hit_event),
        .miss_event       (miss_event),
        .extract_en       (extract_en),
        .extract_sel_fill (extract_sel_fill),
        .extract_req      (extract_req)
    );

    dcache_array u_array (
        .clock           (clock),
        .reset           (reset),
        .lookup_addr     (load_req.addr),
        .cache_ctrl      (cache_ctrl),
        .store_req       (store_req),
        .store_accept    (store_accept),
        .fill_en         (fill_en),
        .fill_set        (fill_set),
        .fill_tag        (fill_tag),
        .fill_data       (mem_resp.data),
        .plru_way        (plru_way),
        .hit             (hit),
        .hit_way         (hit_way),
        .hit_line        (hit_line),
        .plru_set        (plru_set),
        .plru_update     (plru_update),
        .plru_update_way (plru_update_way)
    );

    tree_plru u_plru (
        .clock      (clock),
        .reset      (reset),
        .lookup_set (plru_set),
        .update     (plru_touch),
        .update_set (plru_set),
        .update_way (plru_touch_way),
        .lru_way    (plru_way)
    );

    load_extract u_extract (
        .clock     (clock),
        .reset     (reset),
        .line      (extract_line),
        .offset    (extract_req.addr[offset_width-1:0]),
        .size      (extract_req.size),
        .is_signed (extract_req.is_signed),
        .dest      (extract_req.dest),
        .capture   (extract_en),
        .load_resp (load_resp)
    );

endmodule

`default_nettype wire

// File: testbench/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int wait_limit = 200;
    localparam int reset_cycles = 4;

    logic                  clock;
    logic                  reset;
    load_req_t             load_req;
    logic                  load_ready;
    load_resp_t            load_resp;
    store_req_t            store_req;
    logic                  store_ready;
    mem_req_t              mem_req;
    logic                  mem_ready;
    mem_resp_t             mem_resp;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [3:0]            paddr;
    logic [word_width-1:0] pwdata;
    logic [word_width-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    // Memory model state
    logic [7:0]            mem [0:65535];
    logic                  resp_pending;
    int                    resp_delay;
    logic [addr_width-1:0] resp_addr;
    int                    mem_load_count;
    int                    misaligned_count;

    int                    error_count;
    int                    test_count;
    logic                  timed_out;
    logic                  test_ok;
    int                    seed_init;

    dcache_top u_dut (
        .clock       (clock),
        .reset       (reset),
        .load_req    (load_req),
        .load_ready  (load_ready),
        .load_resp   (load_resp),
        .store_req   (store_req),
        .store_ready (store_ready),
        .mem_req     (mem_req),
        .mem_ready   (mem_ready),
        .mem_resp    (mem_resp),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a] = a[7:0] ^ 8'h5a;
        end
    end

    // Memory model with random back-pressure and a line response 1 to 4 cycles after a load
    always @(posedge clock) begin
        if (reset) begin
            mem_ready    <= 1'b0;
            mem_resp     <= '0;
            resp_pending <= 1'b0;
            resp_delay   <= 0;
        end else begin
            mem_ready      <= ($urandom % 4) != 0;
            mem_resp.valid <= 1'b0;
            if (mem_req.valid && mem_ready) begin
                if (mem_req.cmd == bus_store) begin
                    mem[mem_req.addr] = mem_req.data[7:0];
                    if (mem_req.size != byte_size) begin
                        mem[mem_req.addr + 16'd1] = mem_req.data[15:8];
                    end
                    if (mem_req.size == word_size) begin
                        mem[mem_req.addr + 16'd2] = mem_req.data[23:16];
                        mem[mem_req.addr + 16'd3] = mem_req.data[31:24];
                    end
                end else begin
                    mem_load_count = mem_load_count + 1;
                    if (mem_req.addr[offset_width-1:0] != 0 || mem_req.size != line_size) begin
                        misaligned_count = misaligned_count + 1;
                    end
                    resp_pending <= 1'b1;
                    resp_delay   <= 1 + ($urandom % 4);
                    resp_addr    <= mem_req.addr;
                end
            end
            if (resp_pending) begin
                if (resp_delay <= 1) begin
                    resp_pending   <= 1'b0;
                    mem_resp.valid <= 1'b1;
                    for (int i = 0; i < 8; i++) begin
                        mem_resp.data[i*8 +: 8] <= mem[resp_addr + 16'(i)];
                    end
                end else begin
                    resp_delay <= resp_delay - 1;
                end
            end
        end
    end

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %0s expected %h actual %h", name, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic load_and_check(input string name, input logic [15:0] addr, input int size,
                                  input logic sgn, input logic [31:0] expected,
                                  input int index);
        int count;
        int loads_before;
        int bad_before;
        int misses;
        @(posedge clock);
        load_req.valid     <= 1'b1;
        load_req.addr      <= addr;
        load_req.size      <= mem_size_e'(size);
        load_req.is_signed <= sgn;
        load_req.dest      <= index[5:0];
        loads_before = mem_load_count;
        bad_before   = misaligned_count;
        count = 0;
        @(negedge clock);
        while (!load_ready && count < wait_limit) begin
            @(negedge clock);
            count++;
        end
        if (!load_ready) begin
            $display("%0s: load was never accepted", name);
            timed_out = 1'b1;
            return;
        end
        @(posedge clock);
        load_req.valid <= 1'b0;
        count = 1;
        @(negedge clock);
        while (!load_resp.valid && count < wait_limit) begin
            @(negedge clock);
            count++;
        end
        if (!load_resp.valid) begin
            $display("%0s: no load response arrived", name);
            timed_out = 1'b1;
            return;
        end
        report_value(name, expected, load_resp.value);
        report_value(name, {26'd0, index[5:0]}, {26'd0, load_resp.dest});
        misses = mem_load_count - loads_before;
        if (misses > 1) begin
            $display("%0s: more than one line request for a single load", name);
            test_ok = 1'b0;
        end
        if (misaligned_count != bad_before) begin
            $display("%0s: line request was not line aligned", name);
            test_ok = 1'b0;
        end
        // A hit answers one cycle after acceptance
        if (misses == 0 && count != 1) begin
            $display("%0s: hit response took %0d cycles", name, count);
            test_ok = 1'b0;
        end
    endtask

    task automatic store_and_drain(input string name, input logic [15:0] addr, input int size,
                                   input logic [31:0] data);
        int count;
        @(posedge clock);
        store_req.valid <= 1'b1;
        store_req.addr  <= addr;
        store_req.size  <= mem_size_e'(size);
        store_req.data  <= data;
        count = 0;
        @(negedge clock);
        while (!store_ready && count < wait_limit) begin
            @(negedge clock);
            count++;
        end
        if (!store_ready) begin
            $display("%0s: store was never accepted", name);
            timed_out = 1'b1;
            return;
        end
        @(posedge clock);
        store_req.valid <= 1'b0;
        // Ready returns once memory has taken the write
        count = 0;
        @(negedge clock);
        while (!store_ready && count < wait_limit) begin
            @(negedge clock);
            count++;
        end
        if (!store_ready) begin
            $display("%0s: memory never took the store", name);
            timed_out = 1'b1;
        end
    endtask

    task automatic apb_transfer(input string name, input logic write, input logic [3:0] addr,
                                input logic [31:0] data, input logic [31:0] expected);
        logic unmapped;
        // Registers sit at offsets 0, 4 and 8
        unmapped = addr != 4'h0 && addr != 4'h4 && addr != 4'h8;
        @(posedge clock);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clock);
        penable <= 1'b1;
        @(negedge clock);
        if (pslverr !== unmapped) begin
            $display("mismatch %0s pslverr expected %b actual %b", name, unmapped, pslverr);
            test_ok = 1'b0;
        end
        if (pready !== 1'b1) begin
            $display("mismatch %0s pready expected 1 actual %b", name, pready);
            test_ok = 1'b0;
        end
        if (!write) begin
            report_value(name, expected, prdata);
        end
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_reset_state(input string name);
        @(negedge clock);
        if (load_resp.valid !== 1'b0 || mem_req.valid !== 1'b0) begin
            $display("%0s: outputs not idle after reset", name);
            test_ok = 1'b0;
        end
    endtask

    initial begin
        int                fd;
        int                code;
        logic [8*128-1:0]  text;
        logic [8*24-1:0]   name_v;
        logic [8*16-1:0]   op_v;
        logic [15:0]       addr;
        int                size;
        int                sgn;
        logic [31:0]       data;
        logic [31:0]       expected;
        string             name;

        seed_init = $urandom(17);
        reset            = 1'b1;
        load_req         = '0;
        store_req        = '0;
        psel             = 1'b0;
        penable          = 1'b0;
        pwrite           = 1'b0;
        paddr            = '0;
        pwdata           = '0;
        mem_ready        = 1'b0;
        mem_resp         = '0;
        resp_pending     = 1'b0;
        resp_delay       = 0;
        resp_addr        = '0;
        mem_load_count   = 0;
        misaligned_count = 0;
        error_count      = 0;
        test_count       = 0;
        timed_out        = 1'b0;

        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;

        fd = $fopen("testbench/dcache_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the input data file");
            timed_out = 1'b1;
        end
        while (fd != 0 && !timed_out && !$feof(fd)) begin
            text = '0;
            code = $fgets(text, fd);
            code = $sscanf(text, "%s %s %h %d %d %h %h",
                           name_v, op_v, addr, size, sgn, data, expected);
            // Comment and blank lines do not parse fully
            if (code == 7) begin
                name    = $sformatf("%0s", name_v);
                test_ok = 1'b1;
                if (op_v == "load") begin
                    load_and_check(name, addr, size, sgn[0], expected, test_count);
                end else if (op_v == "store") begin
                    store_and_drain(name, addr, size, data);
                end else if (op_v == "apb_read") begin
                    apb_transfer(name, 1'b0, addr[3:0], data, expected);
                end else if (op_v == "apb_write") begin
                    apb_transfer(name, 1'b1, addr[3:0], data, expected);
                end else if (op_v == "reset_check") begin
                    check_reset_state(name);
                end else begin
                    $display("%0s: unknown operation in input file", name);
                    test_ok = 1'b0;
                end
                test_count++;
                if (timed_out) begin
                    test_ok = 1'b0;
                end
                if (!test_ok) begin
                    error_count++;
                end
                $display("%0s: %0s", name, test_ok ? "ok" : "FAILED");
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("%0d tests run, %0d failed", test_count, error_count);
        if (error_count == 0 && !timed_out && test_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/dcache_input.txt
# name op addr(hex) size(0 byte, 1 half, 2 word) signed data(hex) expected(hex)
# memory byte at address a starts as a[7:0] ^ 5a
reset_state reset_check 0000 0 0 0 0
hits_zero apb_read 4 0 0 0 0
misses_zero apb_read 8 0 0 0 0
word_miss load 0100 2 0 0 59585b5a
word_hit load 0104 2 0 0 5d5c5f5e
byte_hit_pos load 0107 0 1 0 0000005d
byte_miss_neg load 01da 0 1 0 ffffff80
byte_hit_uns load 01da 0 0 0 00000080
half_hit_neg load 01dc 1 1 0 ffff8786
half_hit_uns load 01de 1 0 0 00008584
store_hit_word store 0104 2 0 deadbeef 0
merged_word load 0104 2 0 0 deadbeef
store_hit_byte store 0101 0 0 77 0
merged_byte load 0100 2 0 0 5958775a
store_miss store 0300 2 0 12345678 0
after_store_miss load 0300 2 0 0 12345678
half_after_fill load 0302 1 0 0 00001234
plru_a load 0410 2 0 0 49484b4a
plru_b load 0810 2 0 0 49484b4a
plru_c load 0c10 2 0 0 49484b4a
plru_d load 1010 2 0 0 49484b4a
plru_a_again load 0410 2 0 0 49484b4a
plru_e load 1410 2 0 0 49484b4a
a_kept load 0410 2 0 0 49484b4a
b_kept load 0810 2 0 0 49484b4a
d_kept load 1010 2 0 0 49484b4a
c_evicted load 0c10 2 0 0 49484b4a
hit_count apb_read 4 0 0 0 0000000c
miss_count apb_read 8 0 0 0 00000009
unmapped_reg apb_read c 0 0 0 0
ctrl_default apb_read 0 0 0 0 1
invalidate apb_write 0 0 0 3 0
ctrl_after_inv apb_read 0 0 0 0 1
reload_after_inv load 0104 2 0 0 deadbeef
disable apb_write 0 0 0 0 0
nocache_first load 0104 2 0 0 deadbeef
nocache_second load 0104 2 0 0 deadbeef
ctrl_off apb_read 0 0 0 0 0
enable apb_write 0 0 0 1 0
final_hits apb_read 4 0 0 0 0000000c
final_misses apb_read 8 0 0 0 0000000c

// File: src.f
rtl/dcache_pkg.sv
rtl/dcache_regs.sv
rtl/tree_plru.sv
rtl/dcache_array.sv
rtl/miss_unit.sv
rtl/load_extract.sv
rtl/dcache_top.sv
testbench/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - rtl/dcache_pkg.sv
  - rtl/dcache_regs.sv
  - rtl/tree_plru.sv
  - rtl/dcache_array.sv
  - rtl/miss_unit.sv
  - rtl/load_extract.sv
  - rtl/dcache_top.sv
  - target: test
    files:
      - testbench/dcache_tb.sv
